// ==== hw/lane_config.svh ====
// Frame, road region, trace and buffer sizes shared by the lane highlight design; include where needed
`ifndef LANE_CONFIG_SVH
`define LANE_CONFIG_SVH

// Scaled-down frame so a full trace stays short in simulation
`define FRAME_WIDTH 64
`define FRAME_HEIGHT 48

// Road region bounds, inclusive on both ends
`define REGION_X0 8
`define REGION_Y0 20
`define REGION_X1 55
`define REGION_Y1 43

// The mask memory covers exactly the road region
`define REGION_WIDTH ((`REGION_X1) - (`REGION_X0) + 1)
`define REGION_HEIGHT ((`REGION_Y1) - (`REGION_Y0) + 1)
`define MASK_DEPTH ((`REGION_WIDTH) * (`REGION_HEIGHT))

// Line parameter walk, k runs from K_START up to K_END - 1
`define K_START (-40)
`define K_END 40

// Highlight half width in columns and the minimum mask byte that counts as road
`define HIGHLIGHT_OFFSET 2
`define MASK_THRESHOLD 8'h0F

// Fraction bits of the quantized sine and cosine tables
`define TRIG_FRAC_BITS 8

// Pixel FIFO entries, which is also the number of credits the tracer starts with
`define FIFO_DEPTH 4

`endif

// ==== hw/lane_pkg.sv ====
// Types and quantized trig tables shared by the lane highlight modules and the testbench
`default_nettype none

`include "lane_config.svh"

package lane_pkg;

    typedef logic signed [15:0] rho_t;
    typedef logic [7:0] theta_t;
    typedef logic signed [11:0] trig_t;
    typedef logic signed [7:0] coord_t;
    typedef logic signed [7:0] k_t;
    typedef logic [$clog2(`FRAME_WIDTH * `FRAME_HEIGHT)-1:0] pixel_addr_t;
    typedef logic [$clog2(`MASK_DEPTH)-1:0] mask_addr_t;
    typedef logic [7:0] mask_t;
    typedef logic [23:0] color_t;
    // Wide enough to count from zero up to FIFO_DEPTH inclusive
    typedef logic [$clog2(`FIFO_DEPTH + 1)-1:0] credit_t;

    typedef struct packed {
        pixel_addr_t addr;
        color_t color;
    } pixel_write_t;

    typedef struct packed {
        rho_t rho;
        theta_t theta;
    } lane_t;

    typedef enum logic [2:0] {
        IDLE,
        LANE_SELECT,
        K_STEP,
        REGION_CHECK,
        MASK_TEST,
        PIXEL_EMIT,
        DRAIN
    } tracer_state_t;

    // Pure red in the byte order of the frame memory
    localparam color_t HIGHLIGHT_COLOR = 24'h0000FF;

    // One entry per whole degree of theta
    localparam int TRIG_ENTRIES = 180;
    localparam real PI = 3.14159265358979323846;

    typedef trig_t [0:TRIG_ENTRIES-1] trig_table_t;

    // Sine of an angle between 0 and 90 degrees from its Taylor series
    // Eight terms are far more than the 8 fraction bits of the table need
    function automatic real sine_first_quadrant(input int degrees);
        real x;
        real term;
        real sum;
        x = real'(degrees) * PI / 180.0;
        term = x;
        sum = x;
        for (int n = 1; n < 8; n++) begin
            term = -term * x * x / real'((2 * n) * (2 * n + 1));
            sum = sum + term;
        end
        return sum;
    endfunction

    // Scale to the table precision and round half away from zero
    function automatic trig_t quantize(input real value);
        real scaled;
        scaled = value * real'(1 << `TRIG_FRAC_BITS);
        if (scaled >= 0.0) begin
            return trig_t'($rtoi(scaled + 0.5));
        end
        return trig_t'($rtoi(scaled - 0.5));
    endfunction

    // Builds the sine table, or the cosine table when use_cosine is set
    // Angles past 90 degrees are folded back onto the first quadrant
    function automatic trig_table_t build_trig_table(input logic use_cosine);
        trig_table_t entries;
        real value;
        for (int deg = 0; deg < TRIG_ENTRIES; deg++) begin
            if (use_cosine) begin
                value = (deg <= 90) ? sine_first_quadrant(90 - deg)
                                    : -sine_first_quadrant(deg - 90);
            end else begin
                value = (deg <= 90) ? sine_first_quadrant(deg)
                                    : sine_first_quadrant(180 - deg);
            end
            entries[deg] = quantize(value);
        end
        return entries;
    endfunction

    localparam trig_table_t SIN_TABLE = build_trig_table(1'b0);
    localparam trig_table_t COS_TABLE = build_trig_table(1'b1);

endpackage

`default_nettype wire

// ==== hw/mask_ram.sv ====
// Road mask memory, written through the load port and read by the lane tracer one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "lane_config.svh"

module mask_ram import lane_pkg::*; (
    input  logic       clock,
    input  logic       load_en,
    input  mask_addr_t load_addr,
    input  mask_t      load_data,
    input  mask_addr_t rd_addr,
    output mask_t      rd_data
);

    // One byte per pixel of the road region, stored row by row
    mask_t mem [0:`MASK_DEPTH-1];

    // Load port, only used while the tracer sits idle
    always_ff @(posedge clock) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // Registered read like a block RAM output
    // The tracer presents the address in REGION_CHECK and samples the byte in MASK_TEST
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/lane_tracer.sv ====
// Walks the left then the right lane, reads the road mask and pushes highlight writes under credits
`timescale 1ns/1ps
`default_nettype none

`include "lane_config.svh"

module lane_tracer import lane_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  lane_t        left_lane,
    input  lane_t        right_lane,
    input  mask_t        mask_rd_data,
    input  logic         credit_return,
    output mask_addr_t   mask_rd_addr,
    output logic         push,
    output pixel_write_t push_data,
    output logic         done
);

    localparam int COORD_MAX = 2 ** ($bits(coord_t) - 1) - 1;
    localparam int COORD_MIN = -(2 ** ($bits(coord_t) - 1));

    tracer_state_t state;

    // Set once the left lane is finished, so LANE_SELECT picks the right lane
    logic right_sel;
    credit_t credits;

    // Line of the current lane and the point under test
    rho_t rho;
    trig_t sin_val;
    trig_t cos_val;
    k_t k;
    coord_t x;
    coord_t y;
    // Column being written while the highlight is drawn around x
    coord_t col;

    logic signed [31:0] x_product;
    logic signed [31:0] y_product;
    logic k_running;
    logic in_region;
    logic mask_hit;
    logic col_in_frame;
    logic last_column;
    logic column_advance;
    lane_t lane_sel;

    // Removes the trig fraction bits with rounding toward zero
    // An arithmetic shift alone would round negative values down, so the sign is handled apart
    // Results beyond the coordinate range saturate, which keeps them outside frame and region
    function automatic coord_t dequantize(input logic signed [31:0] product);
        logic signed [31:0] quotient;
        if (product < 0) begin
            quotient = -((-product) >>> `TRIG_FRAC_BITS);
        end else begin
            quotient = product >>> `TRIG_FRAC_BITS;
        end
        if (quotient > COORD_MAX) begin
            return coord_t'(COORD_MAX);
        end
        if (quotient < COORD_MIN) begin
            return coord_t'(COORD_MIN);
        end
        return coord_t'(quotient);
    endfunction

    assign lane_sel = right_sel ? right_lane : left_lane;

    // Point on the line for the current k
    // All operands are signed, so the products widen to 32 bits with sign extension
    always_comb begin
        x_product = rho * cos_val - k * sin_val;
        y_product = rho * sin_val + k * cos_val;
    end

    assign k_running = (k < `K_END);
    assign in_region = (x >= `REGION_X0) && (x <= `REGION_X1)
                    && (y >= `REGION_Y0) && (y <= `REGION_Y1);
    assign mask_hit = (mask_rd_data >= `MASK_THRESHOLD);
    assign col_in_frame = (col >= 0) && (col < `FRAME_WIDTH);
    assign last_column = (col == x + `HIGHLIGHT_OFFSET);

    // A column out of the frame is skipped at once, one inside waits for a credit
    assign column_advance = !col_in_frame || (credits != '0);

    // Region-relative address of the point, only meaningful inside the region
    assign mask_rd_addr = mask_addr_t'((y - `REGION_Y0) * `REGION_WIDTH + (x - `REGION_X0));

    assign push = (state == PIXEL_EMIT) && col_in_frame && (credits != '0);
    assign push_data.addr = pixel_addr_t'(y * `FRAME_WIDTH + col);
    assign push_data.color = HIGHLIGHT_COLOR;

    // All credits back means the FIFO and the writer have both drained
    assign done = (state == DRAIN) && (credits == credit_t'(`FIFO_DEPTH));

    // Control FSM
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            right_sel <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        right_sel <= 1'b0;
                        state <= LANE_SELECT;
                    end
                end
                LANE_SELECT: begin
                    state <= K_STEP;
                end
                K_STEP: begin
                    if (k_running) begin
                        state <= REGION_CHECK;
                    end else if (!right_sel) begin
                        right_sel <= 1'b1;
                        state <= LANE_SELECT;
                    end else begin
                        state <= DRAIN;
                    end
                end
                REGION_CHECK: begin
                    state <= in_region ? MASK_TEST : K_STEP;
                end
                MASK_TEST: begin
                    state <= mask_hit ? PIXEL_EMIT : K_STEP;
                end
                PIXEL_EMIT: begin
                    if (column_advance && last_column) begin
                        state <= K_STEP;
                    end
                end
                DRAIN: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Datapath registers follow the FSM
    always_ff @(posedge clock) begin
        case (state)
            LANE_SELECT: begin
                rho <= lane_sel.rho;
                sin_val <= SIN_TABLE[lane_sel.theta];
                cos_val <= COS_TABLE[lane_sel.theta];
                k <= k_t'(`K_START);
            end
            K_STEP: begin
                x <= dequantize(x_product);
                y <= dequantize(y_product);
            end
            REGION_CHECK: begin
                if (!in_region) begin
                    k <= k + k_t'(1);
                end
            end
            MASK_TEST: begin
                if (mask_hit) begin
                    col <= coord_t'(x - `HIGHLIGHT_OFFSET);
                end else begin
                    k <= k + k_t'(1);
                end
            end
            PIXEL_EMIT: begin
                if (column_advance) begin
                    if (last_column) begin
                        k <= k + k_t'(1);
                    end else begin
                        col <= col + coord_t'(1);
                    end
                end
            end
            default: begin
            end
        endcase
    end

    // Credit counter, a push and a returned credit in one cycle cancel out
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits <= credit_t'(`FIFO_DEPTH);
        end else begin
            case ({push, credit_return})
                2'b10: credits <= credits - credit_t'(1);
                2'b01: credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/pixel_fifo.sv ====
// Circular buffer for pixel writes between the tracer and the image writer, returns a credit per pop
`timescale 1ns/1ps
`default_nettype none

`include "lane_config.svh"

module pixel_fifo import lane_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         push,
    input  pixel_write_t push_data,
    input  logic         pop,
    output logic         head_valid,
    output pixel_write_t head_data,
    output logic         credit_return
);

    localparam int PTR_W = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;

    pixel_write_t mem [0:`FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_t count;

    // Pointers wrap at the last entry, so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign head_valid = (count != '0);
    assign head_data = mem[rd_ptr];

    // The tracer only pushes with a credit in hand, so a push never meets a full buffer
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + credit_t'(1);
                2'b01: count <= count - credit_t'(1);
                default: count <= count;
            endcase
            // One credit goes back the cycle after each pop
            credit_return <= pop;
        end
    end

endmodule

`default_nettype wire

// ==== hw/image_writer.sv ====
// Presents the FIFO head on the frame memory write port and holds it until the port accepts it
`timescale 1ns/1ps
`default_nettype none

module image_writer import lane_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         head_valid,
    input  pixel_write_t head_data,
    input  logic         frame_wr_ready,
    output logic         pop,
    output logic         frame_wr_valid,
    output pixel_write_t frame_wr_data
);

    logic load;

    // The output register copies the head when it is empty
    // The head leaves the FIFO only on acceptance, so each credit comes back after its write is done
    assign load = !frame_wr_valid && head_valid;
    assign pop = frame_wr_valid && frame_wr_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            frame_wr_valid <= 1'b0;
        end else if (pop) begin
            frame_wr_valid <= 1'b0;
        end else if (load) begin
            frame_wr_valid <= 1'b1;
        end
    end

    // Data changes only while the register is empty, which keeps it stable through a stall
    always_ff @(posedge clock) begin
        if (load) begin
            frame_wr_data <= head_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lane_highlight_top.sv ====
// Lane highlight top level joining the mask memory, lane tracer, pixel FIFO and image writer
`timescale 1ns/1ps
`default_nettype none

module lane_highlight_top import lane_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  lane_t        left_lane,
    input  lane_t        right_lane,
    input  logic         mask_load_en,
    input  mask_addr_t   mask_load_addr,
    input  mask_t        mask_load_data,
    input  logic         frame_wr_ready,
    output logic         frame_wr_valid,
    output pixel_write_t frame_wr_data,
    output logic         done
);

    mask_addr_t mask_rd_addr;
    mask_t mask_rd_data;
    logic push;
    pixel_write_t push_data;
    logic pop;
    logic head_valid;
    pixel_write_t head_data;
    logic credit_return;

    mask_ram mask_ram_i (
        .clock     (clock),
        .load_en   (mask_load_en),
        .load_addr (mask_load_addr),
        .load_data (mask_load_data),
        .rd_addr   (mask_rd_addr),
        .rd_data   (mask_rd_data)
    );

    // Producer of the credit loop
    lane_tracer lane_tracer_i (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .left_lane     (left_lane),
        .right_lane    (right_lane),
        .mask_rd_data  (mask_rd_data),
        .credit_return (credit_return),
        .mask_rd_addr  (mask_rd_addr),
        .push          (push),
        .push_data     (push_data),
        .done          (done)
    );

    pixel_fifo pixel_fifo_i (
        .clock         (clock),
        .reset         (reset),
        .push          (push),
        .push_data     (push_data),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_data     (head_data),
        .credit_return (credit_return)
    );

    // Consumer, stalled by the external frame memory
    image_writer image_writer_i (
        .clock          (clock),
        .reset          (reset),
        .head_valid     (head_valid),
        .head_data      (head_data),
        .frame_wr_ready (frame_wr_ready),
        .pop            (pop),
        .frame_wr_valid (frame_wr_valid),
        .frame_wr_data  (frame_wr_data)
    );

endmodule

`default_nettype wire

// ==== test/lane_highlight_properties.sv ====
// Concurrent checks on the credit loop and frame write port, bound into the tracer and writer
`timescale 1ns/1ps
`default_nettype none

`include "lane_config.svh"

module lane_highlight_properties import lane_pkg::*; (
    input logic         clock,
    input logic         reset,
    input logic         push,
    input logic         credit_return,
    input credit_t      credits,
    input logic         frame_wr_valid,
    input logic         frame_wr_ready,
    input pixel_write_t frame_wr_data
);

    // Entries pushed whose credit has not come back yet, counted apart from the tracer
    int in_flight;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            in_flight <= 0;
        end else if (push && !credit_return) begin
            in_flight <= in_flight + 1;
        end else if (credit_return && !push) begin
            in_flight <= in_flight - 1;
        end
    end

    // The FIFO has no full flag, so a push must never find every entry outstanding
    push_has_credit: assert property (
        @(posedge clock) disable iff (reset) push |-> (in_flight < `FIFO_DEPTH)
    ) else $error("push issued with every FIFO entry still outstanding");

    // Credits come back once per pop and can never exceed the buffer depth
    credits_bounded: assert property (
        @(posedge clock) disable iff (reset) credits <= credit_t'(`FIFO_DEPTH)
    ) else $error("credit count rose above the FIFO depth");

    // A stalled transfer keeps valid high and its data unchanged
    stall_holds_data: assert property (
        @(posedge clock) disable iff (reset)
        (frame_wr_valid && !frame_wr_ready) |=> (frame_wr_valid && $stable(frame_wr_data))
    ) else $error("frame write changed or dropped while stalled");

endmodule

bind lane_tracer lane_highlight_properties tracer_props_i (
    .clock          (clock),
    .reset          (reset),
    .push           (push),
    .credit_return  (credit_return),
    .credits        (credits),
    .frame_wr_valid (1'b0),
    .frame_wr_ready (1'b0),
    .frame_wr_data  ('0)
);

bind image_writer lane_highlight_properties writer_props_i (
    .clock          (clock),
    .reset          (reset),
    .push           (1'b0),
    .credit_return  (1'b0),
    .credits        (credit_t'(0)),
    .frame_wr_valid (frame_wr_valid),
    .frame_wr_ready (frame_wr_ready),
    .frame_wr_data  (frame_wr_data)
);

`default_nettype wire

// ==== test/lane_highlight_tb.sv ====
// Table-driven testbench for lane_highlight_top that checks every frame write against a lane model
`timescale 1ns/1ps
`default_nettype none

`include "lane_config.svh"

module lane_highlight_tb import lane_pkg::*; ();

    localparam int CLOCK_PERIOD = 8;
    localparam int NUM_ROWS = 8;
    // Generous bound per row on the lane walk, scaled by the number of rows
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (`K_END - `K_START) * 40;
    localparam color_t RED = 24'h0000FF;

    typedef logic [1:0] pattern_t;

    localparam pattern_t PAT_ALL_ONES = 2'd0;
    localparam pattern_t PAT_ALL_ZERO = 2'd1;
    localparam pattern_t PAT_LEFT_HALF = 2'd2;
    localparam pattern_t PAT_CHECKER = 2'd3;

    typedef struct packed {
        lane_t left;
        lane_t right;
        pattern_t pattern;
        logic [7:0] stall_pct;
    } row_t;

    // Left lane, right lane, mask pattern and percentage of cycles with ready low
    localparam row_t ROWS [0:NUM_ROWS-1] = '{
        '{'{16'sd40, 8'd45}, '{16'sd50, 8'd0}, PAT_ALL_ONES, 8'd0},
        '{'{16'sd40, 8'd45}, '{16'sd50, 8'd0}, PAT_ALL_ZERO, 8'd0},
        // Vertical lanes on the left and right edges of the road region
        '{'{16'sd8, 8'd0}, '{16'sd55, 8'd0}, PAT_ALL_ONES, 8'd0},
        '{'{16'sd20, 8'd90}, '{16'sd43, 8'd90}, PAT_ALL_ONES, 8'd25},
        '{'{16'sd40, 8'd45}, '{16'sd50, 8'd0}, PAT_ALL_ONES, 8'd70},
        '{'{16'sd40, 8'd45}, '{-16'sd45, 8'd170}, PAT_LEFT_HALF, 8'd20},
        '{'{16'sd30, 8'd60}, '{16'sd10, 8'd150}, PAT_CHECKER, 8'd50},
        // One column outside the region on either side, so nothing may be drawn
        '{'{16'sd7, 8'd0}, '{16'sd56, 8'd0}, PAT_ALL_ONES, 8'd0}
    };

    logic clock;
    logic reset;
    logic start;
    lane_t left_lane;
    lane_t right_lane;
    logic mask_load_en;
    mask_addr_t mask_load_addr;
    mask_t mask_load_data;
    logic frame_wr_ready;
    logic frame_wr_valid;
    pixel_write_t frame_wr_data;
    logic done;

    integer seed;
    int stall_pct;
    // Set while a trace runs, from the start pulse until done is seen
    logic busy;
    logic done_seen;
    int got_count;
    pixel_write_t expected_q [$];
    mask_t mask_image [0:`MASK_DEPTH-1];

    lane_highlight_top dut_i (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .left_lane      (left_lane),
        .right_lane     (right_lane),
        .mask_load_en   (mask_load_en),
        .mask_load_addr (mask_load_addr),
        .mask_load_data (mask_load_data),
        .frame_wr_ready (frame_wr_ready),
        .frame_wr_valid (frame_wr_valid),
        .frame_wr_data  (frame_wr_data),
        .done           (done)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic end_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic explain_failure(input string reason);
        $display("%s", reason);
        end_with_failure();
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error: %s expected %0h got %0h", name, expected, actual);
        end_with_failure();
    endtask

    // Mask byte for a region address, set entries range from the threshold up to FF
    // Clear entries stay just below the threshold so the compare is tried at its edge
    function automatic mask_t mask_value(input pattern_t pattern, input int addr);
        int column;
        logic set;
        column = addr % `REGION_WIDTH;
        case (pattern)
            PAT_ALL_ONES: set = 1'b1;
            PAT_ALL_ZERO: set = 1'b0;
            PAT_LEFT_HALF: set = (column < `REGION_WIDTH / 2);
            default: set = (column % 2 == 0);
        endcase
        if (set) begin
            return mask_t'(`MASK_THRESHOLD + (addr * 13) % 241);
        end
        return mask_t'((addr * 7) % 15);
    endfunction

    task automatic load_mask(input pattern_t pattern);
        mask_t value;
        for (int a = 0; a < `MASK_DEPTH; a++) begin
            value = mask_value(pattern, a);
            mask_image[a] = value;
            @(posedge clock);
            mask_load_en <= 1'b1;
            mask_load_addr <= mask_addr_t'(a);
            mask_load_data <= value;
        end
        @(posedge clock);
        mask_load_en <= 1'b0;
    endtask

    // Lane model: walk k, find the point, test region and mask, then draw the clipped columns
    task automatic add_lane_writes(input lane_t lane);
        int rho;
        int sin_q;
        int cos_q;
        int x;
        int y;
        int addr;
        pixel_write_t w;
        rho = int'(lane.rho);
        sin_q = int'(SIN_TABLE[lane.theta]);
        cos_q = int'(COS_TABLE[lane.theta]);
        for (int k = `K_START; k < `K_END; k++) begin
            // Signed integer division already truncates toward zero
            x = (rho * cos_q - k * sin_q) / (1 << `TRIG_FRAC_BITS);
            y = (rho * sin_q + k * cos_q) / (1 << `TRIG_FRAC_BITS);
            if (x >= `REGION_X0 && x <= `REGION_X1 && y >= `REGION_Y0 && y <= `REGION_Y1) begin
                addr = (y - `REGION_Y0) * `REGION_WIDTH + (x - `REGION_X0);
                if (mask_image[addr] >= `MASK_THRESHOLD) begin
                    for (int c = x - `HIGHLIGHT_OFFSET; c <= x + `HIGHLIGHT_OFFSET; c++) begin
                        if (c >= 0 && c < `FRAME_WIDTH) begin
                            w.addr = pixel_addr_t'(y * `FRAME_WIDTH + c);
                            w.color = RED;
                            expected_q.push_back(w);
                        end
                    end
                end
            end
        end
    endtask

    task automatic run_row(input row_t row);
        @(negedge clock);
        stall_pct = int'(row.stall_pct);
        load_mask(row.pattern);
        expected_q.delete();
        add_lane_writes(row.left);
        add_lane_writes(row.right);
        got_count = 0;
        done_seen = 1'b0;
        @(posedge clock);
        left_lane <= row.left;
        right_lane <= row.right;
        start <= 1'b1;
        busy = 1'b1;
        @(posedge clock);
        start <= 1'b0;
        while (!done_seen) begin
            @(posedge clock);
        end
    endtask

    // Random back-pressure from the frame memory, ready is low for stall_pct percent of cycles
    always @(posedge clock) begin
        frame_wr_ready <= ((($random(seed) & 32'h7FFF_FFFF) % 100) >= stall_pct);
    end

    // Outputs are sampled mid-cycle, where they are settled
    always @(negedge clock) begin
        if (frame_wr_valid && frame_wr_ready) begin
            assert (got_count < expected_q.size())
                else explain_failure("More frame writes were accepted than the model predicts");
            assert (frame_wr_data == expected_q[got_count])
                else report_mismatch("frame_wr_data", expected_q[got_count], frame_wr_data);
            got_count++;
        end
        if (busy && done) begin
            assert (got_count == expected_q.size())
                else report_mismatch("accepted write count", expected_q.size(), got_count);
            assert (!frame_wr_valid)
                else explain_failure("done arrived while a frame write was still pending");
            busy = 1'b0;
            done_seen = 1'b1;
        end else if (!busy) begin
            assert (!frame_wr_valid)
                else explain_failure("frame_wr_valid went high while no trace was running");
            assert (!done)
                else explain_failure("done pulsed while no trace was running");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        explain_failure("The watchdog expired before all rows finished");
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        left_lane = '0;
        right_lane = '0;
        mask_load_en = 1'b0;
        mask_load_addr = '0;
        mask_load_data = '0;
        frame_wr_ready = 1'b0;
        seed = 86;
        stall_pct = 0;
        busy = 1'b0;
        done_seen = 1'b0;
        got_count = 0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(ROWS[r]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lane_highlight_top.f ====
+incdir+hw
hw/lane_pkg.sv
hw/mask_ram.sv
hw/lane_tracer.sv
hw/pixel_fifo.sv
hw/image_writer.sv
hw/lane_highlight_top.sv
test/lane_highlight_properties.sv
test/lane_highlight_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= lane_highlight_tb
FILELIST ?= lane_highlight_top.f
BUILD_DIR ?= obj_dir
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
